//--- filelist.f
rtl/udp_rx_pkg.sv
rtl/rx_sync_fifo.sv
rtl/rx_header_parser.sv
rtl/rx_app_writer.sv
rtl/rx_cpu_buffer.sv
rtl/udp_rx.sv
verif/udp_rx_props.sv
verif/udp_rx_tb.sv

//--- rtl/rx_app_writer.sv
module rx_app_writer (
  input  logic                    mac_clk,
  input  logic                    mac_rst,
  input  udp_rx_pkg::byte_t       rx_data,
  input  logic                    rx_dvld,
  input  udp_rx_pkg::rx_verdict_t verdict,
  input  udp_rx_pkg::rx_src_t     src,
  input  logic                    pkt_overflow,
  input  logic                    ctrl_overflow,
  input  logic                    app_flush,
  output logic                    pkt_wr,
  output udp_rx_pkg::rx_byte_t    pkt_din,
  output logic                    ctrl_wr,
  output udp_rx_pkg::rx_src_t     ctrl_din,
  output logic                    app_overrun
);

  import udp_rx_pkg::*;

  byte_t dly_data;
  logic  dly_dvld;
  logic  eof;
  logic  any_overflow;
  logic  blocked;

  // second byte stage, lines up with the verdict
  always_ff @(posedge mac_clk) begin
    dly_data <= rx_data;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      dly_dvld <= 1'b0;
    end else begin
      dly_dvld <= rx_dvld;
    end
  end

  // last byte when the stage behind it is empty
  assign eof = dly_dvld && !rx_dvld;

  assign any_overflow = pkt_overflow || ctrl_overflow;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      app_overrun <= 1'b0;
    end else if (app_flush) begin
      app_overrun <= 1'b0;
    end else if (any_overflow) begin
      app_overrun <= 1'b1;
    end
  end

  // stay blocked until flushed and between frames, so no partial frame is written
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      blocked <= 1'b0;
    end else if (any_overflow) begin
      blocked <= 1'b1;
    end else if (blocked && !app_overrun && !rx_dvld && !dly_dvld) begin
      blocked <= 1'b0;
    end
  end

  assign pkt_din = '{data: dly_data, eof: eof};
  assign pkt_wr  = verdict.in_data && verdict.app_ok && !blocked;

  // source entry goes in once, alongside the first payload byte
  assign ctrl_din = src;
  assign ctrl_wr  = verdict.first && verdict.app_ok && !blocked;

endmodule

//--- rtl/rx_cpu_buffer.sv
module rx_cpu_buffer (
  input  logic                    mac_clk,
  input  logic                    mac_rst,
  input  udp_rx_pkg::byte_t       rx_data,
  input  logic                    rx_dvld,
  input  udp_rx_pkg::rx_verdict_t verdict,
  input  logic                    mac_rx_goodframe,
  input  logic                    mac_rx_badframe,
  input  logic                    cpu_ack,
  output udp_rx_pkg::cpu_addr_t   cpu_addr,
  output udp_rx_pkg::byte_t       cpu_wr_data,
  output logic                    cpu_wr_en,
  output udp_rx_pkg::cpu_addr_t   cpu_size,
  output logic                    cpu_ready,
  output logic                    cpu_buffer_sel
);

  import udp_rx_pkg::*;

  cpu_state_e state;
  byte_t      d_data;
  logic       d_dvld;
  cpu_addr_t  count;
  logic       invalid;
  logic       good_seen;
  logic       bad_seen;
  logic       frame_start;

  always_ff @(posedge mac_clk) begin
    d_data <= rx_data;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      d_dvld <= 1'b0;
    end else begin
      d_dvld <= rx_dvld;
    end
  end

  assign frame_start = rx_dvld && !d_dvld;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state          <= RX_CPU_IDLE;
      count          <= '0;
      invalid        <= 1'b0;
      good_seen      <= 1'b0;
      bad_seen       <= 1'b0;
      cpu_ready      <= 1'b0;
      cpu_buffer_sel <= 1'b0;
    end else begin
      case (state)
        RX_CPU_IDLE: begin
          count     <= '0;
          invalid   <= 1'b0;
          good_seen <= 1'b0;
          bad_seen  <= 1'b0;
          if (frame_start) begin
            state <= RX_CPU_DATA;
          end
        end
        RX_CPU_DATA: begin
          // the MAC status pulse can land before the last byte leaves the pipe
          if (mac_rx_goodframe) begin
            good_seen <= 1'b1;
          end
          if (mac_rx_badframe) begin
            bad_seen <= 1'b1;
          end
          if (d_dvld) begin
            count <= count + 1'b1;
            if (count == '1) begin
              invalid <= 1'b1;
            end
            // verdict is complete on the last byte
            if (!rx_dvld && !verdict.cpu_ok) begin
              invalid <= 1'b1;
            end
          end else begin
            state <= RX_CPU_VALIDATE;
          end
        end
        RX_CPU_VALIDATE: begin
          if (bad_seen || mac_rx_badframe || invalid) begin
            state <= RX_CPU_IDLE;
          end else if (good_seen || mac_rx_goodframe) begin
            state     <= RX_CPU_HANDSHAKE;
            cpu_ready <= 1'b1;
          end else if (frame_start) begin
            state <= RX_CPU_IDLE;
          end
        end
        default: begin
          if (cpu_ready && cpu_ack) begin
            cpu_ready      <= 1'b0;
            cpu_buffer_sel <= !cpu_buffer_sel;
          end else if (!cpu_ready && !cpu_ack) begin
            state <= RX_CPU_IDLE;
          end
        end
      endcase
    end
  end

  assign cpu_wr_en   = (state == RX_CPU_DATA) && d_dvld;
  assign cpu_addr    = count;
  assign cpu_wr_data = d_data;
  assign cpu_size    = count;

endmodule

//--- rtl/rx_header_parser.sv
module rx_header_parser (
  input  logic                    mac_clk,
  input  logic                    mac_rst,
  input  udp_rx_pkg::byte_t       mac_rx_data,
  input  logic                    mac_rx_dvld,
  input  udp_rx_pkg::rx_local_t   local_cfg,
  input  logic                    cpu_promiscuous,
  output udp_rx_pkg::byte_t       rx_data,
  output logic                    rx_dvld,
  output udp_rx_pkg::rx_verdict_t verdict,
  output udp_rx_pkg::rx_src_t     src
);

  import udp_rx_pkg::*;

  rx_state_e  state;
  logic [4:0] off;
  logic       frame_start;
  logic       dst_local;
  logic       dst_bcast;
  logic       mac_ok;
  logic       hdr_ok;
  logic       hdr_done;
  logic       app_ok;
  logic       in_data_q;
  logic       first_q;

  // byte idx counts from the least significant byte of the field
  function automatic byte_t field_byte(input logic [47:0] field, input int idx);
    return byte_t'(field >> (8 * idx));
  endfunction

  assign frame_start = (state == RX_IDLE) && mac_rx_dvld;

  always_ff @(posedge mac_clk) begin
    rx_data <= mac_rx_data;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      rx_dvld <= 1'b0;
    end else begin
      rx_dvld <= mac_rx_dvld;
    end
  end

  // state and offset describe the byte now held in rx_data
  always_ff @(posedge mac_clk) begin
    if (mac_rst || !mac_rx_dvld) begin
      state <= RX_IDLE;
      off   <= '0;
    end else begin
      off <= off + 1'b1;
      case (state)
        RX_IDLE: begin
          state <= RX_MAC;
          off   <= '0;
        end
        RX_MAC: begin
          if (off == MAC_HDR_LEN - 1) begin
            state <= RX_IP;
            off   <= '0;
          end
        end
        RX_IP: begin
          if (off == IP_HDR_LEN - 1) begin
            state <= RX_UDP;
            off   <= '0;
          end
        end
        RX_UDP: begin
          if (off == UDP_HDR_LEN - 1) begin
            state <= RX_DATA;
            off   <= '0;
          end
        end
        default: begin
          off <= '0;
        end
      endcase
    end
  end

  // accept flags hold after the frame until the next one starts
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      dst_local <= 1'b0;
      dst_bcast <= 1'b0;
      hdr_ok    <= 1'b0;
      hdr_done  <= 1'b0;
    end else if (frame_start) begin
      dst_local <= 1'b1;
      dst_bcast <= 1'b1;
      hdr_ok    <= local_cfg.enable;
      hdr_done  <= 1'b0;
    end else begin
      case (state)
        RX_MAC: begin
          // destination address, all six bytes local or all six broadcast
          if (off <= 5 && rx_data != field_byte(local_cfg.mac, 5 - int'(off))) begin
            dst_local <= 1'b0;
          end
          if (off <= 5 && rx_data != 8'hff) begin
            dst_bcast <= 1'b0;
          end
          if (off == 12 && rx_data != ETHERTYPE_IPV4[15:8]) begin
            hdr_ok <= 1'b0;
          end
          if (off == 13 && rx_data != ETHERTYPE_IPV4[7:0]) begin
            hdr_ok <= 1'b0;
          end
        end
        RX_IP: begin
          if (off == 0 && rx_data != IP_VER_IHL) begin
            hdr_ok <= 1'b0;
          end
          if (off == 9 && rx_data != IP_PROTO_UDP) begin
            hdr_ok <= 1'b0;
          end
          if (off >= 16 && rx_data != field_byte(48'(local_cfg.ip), 19 - int'(off))) begin
            hdr_ok <= 1'b0;
          end
        end
        RX_UDP: begin
          if ((off == 2 || off == 3) &&
              rx_data != field_byte(48'(local_cfg.port), 3 - int'(off))) begin
            hdr_ok <= 1'b0;
          end
          if (off == UDP_HDR_LEN - 1) begin
            hdr_done <= 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // source address and port shift in msb first
  always_ff @(posedge mac_clk) begin
    if (state == RX_IP && off >= 12 && off <= 15) begin
      src.ip <= {src.ip[23:0], rx_data};
    end
    if (state == RX_UDP && off <= 1) begin
      src.port <= {src.port[7:0], rx_data};
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      in_data_q <= 1'b0;
      first_q   <= 1'b0;
    end else begin
      in_data_q <= (state == RX_DATA);
      first_q   <= (state == RX_DATA) && !in_data_q;
    end
  end

  assign mac_ok  = dst_local || dst_bcast;
  assign app_ok  = hdr_done && mac_ok && hdr_ok;
  assign verdict = '{
    app_ok:  app_ok,
    cpu_ok:  (mac_ok || cpu_promiscuous) && !app_ok,
    in_data: in_data_q,
    first:   first_q
  };

endmodule

//--- rtl/rx_sync_fifo.sv
module rx_sync_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 16
) (
  input  logic   mac_clk,
  input  logic   mac_rst,
  input  logic   flush,
  input  logic   wr_en,
  input  entry_t din,
  input  logic   rd_en,
  output entry_t dout,
  output logic   empty,
  output logic   overflow
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  // wraps at DEPTH so that depths other than powers of two work too
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));
  assign do_wr    = wr_en && !full;
  assign do_rd    = rd_en && !empty;
  assign overflow = wr_en && full;

  // show-ahead, head entry is always on dout
  assign dout = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/udp_rx.sv
module udp_rx (
  input  logic                  mac_clk,
  input  logic                  mac_rst,
  input  udp_rx_pkg::byte_t     mac_rx_data,
  input  logic                  mac_rx_dvld,
  input  logic                  mac_rx_goodframe,
  input  logic                  mac_rx_badframe,
  input  logic                  local_enable,
  input  udp_rx_pkg::mac_addr_t local_mac,
  input  udp_rx_pkg::ip_addr_t  local_ip,
  input  udp_rx_pkg::udp_port_t local_port,
  input  logic                  cpu_promiscuous,
  output udp_rx_pkg::byte_t     app_data,
  output logic                  app_dvld,
  output logic                  app_eof,
  output udp_rx_pkg::ip_addr_t  app_srcip,
  output udp_rx_pkg::udp_port_t app_srcport,
  output logic                  app_overrun,
  input  logic                  app_ack,
  input  logic                  app_flush,
  output udp_rx_pkg::cpu_addr_t cpu_addr,
  output udp_rx_pkg::byte_t     cpu_wr_data,
  output logic                  cpu_wr_en,
  output udp_rx_pkg::cpu_addr_t cpu_size,
  output logic                  cpu_ready,
  output logic                  cpu_buffer_sel,
  input  logic                  cpu_ack
);

  import udp_rx_pkg::*;

  rx_local_t   local_cfg;
  byte_t       rx_data;
  logic        rx_dvld;
  rx_verdict_t verdict;
  rx_src_t     src;

  logic        pkt_wr;
  rx_byte_t    pkt_din;
  rx_byte_t    pkt_dout;
  logic        pkt_rd;
  logic        pkt_empty;
  logic        pkt_overflow;

  logic        ctrl_wr;
  rx_src_t     ctrl_din;
  rx_src_t     ctrl_dout;
  logic        ctrl_rd;
  logic        ctrl_empty;
  logic        ctrl_overflow;

  assign local_cfg = '{enable: local_enable, mac: local_mac, ip: local_ip, port: local_port};

  rx_header_parser parser_i (
    .mac_clk         (mac_clk),
    .mac_rst         (mac_rst),
    .mac_rx_data     (mac_rx_data),
    .mac_rx_dvld     (mac_rx_dvld),
    .local_cfg       (local_cfg),
    .cpu_promiscuous (cpu_promiscuous),
    .rx_data         (rx_data),
    .rx_dvld         (rx_dvld),
    .verdict         (verdict),
    .src             (src)
  );

  rx_app_writer writer_i (
    .mac_clk       (mac_clk),
    .mac_rst       (mac_rst),
    .rx_data       (rx_data),
    .rx_dvld       (rx_dvld),
    .verdict       (verdict),
    .src           (src),
    .pkt_overflow  (pkt_overflow),
    .ctrl_overflow (ctrl_overflow),
    .app_flush     (app_flush),
    .pkt_wr        (pkt_wr),
    .pkt_din       (pkt_din),
    .ctrl_wr       (ctrl_wr),
    .ctrl_din      (ctrl_din),
    .app_overrun   (app_overrun)
  );

  rx_sync_fifo #(.entry_t(rx_byte_t), .DEPTH(PKT_FIFO_DEPTH)) pkt_fifo_i (
    .mac_clk  (mac_clk),
    .mac_rst  (mac_rst),
    .flush    (app_flush),
    .wr_en    (pkt_wr),
    .din      (pkt_din),
    .rd_en    (pkt_rd),
    .dout     (pkt_dout),
    .empty    (pkt_empty),
    .overflow (pkt_overflow)
  );

  rx_sync_fifo #(.entry_t(rx_src_t), .DEPTH(CTRL_FIFO_DEPTH)) ctrl_fifo_i (
    .mac_clk  (mac_clk),
    .mac_rst  (mac_rst),
    .flush    (app_flush),
    .wr_en    (ctrl_wr),
    .din      (ctrl_din),
    .rd_en    (ctrl_rd),
    .dout     (ctrl_dout),
    .empty    (ctrl_empty),
    .overflow (ctrl_overflow)
  );

  rx_cpu_buffer cpu_buf_i (
    .mac_clk          (mac_clk),
    .mac_rst          (mac_rst),
    .rx_data          (rx_data),
    .rx_dvld          (rx_dvld),
    .verdict          (verdict),
    .mac_rx_goodframe (mac_rx_goodframe),
    .mac_rx_badframe  (mac_rx_badframe),
    .cpu_ack          (cpu_ack),
    .cpu_addr         (cpu_addr),
    .cpu_wr_data      (cpu_wr_data),
    .cpu_wr_en        (cpu_wr_en),
    .cpu_size         (cpu_size),
    .cpu_ready        (cpu_ready),
    .cpu_buffer_sel   (cpu_buffer_sel)
  );

  assign app_dvld    = !pkt_empty;
  assign app_data    = pkt_dout.data;
  assign app_eof     = pkt_dout.eof;
  assign app_srcip   = ctrl_dout.ip;
  assign app_srcport = ctrl_dout.port;

  // source entry leaves with the last payload byte of its frame
  assign pkt_rd  = app_ack && app_dvld;
  assign ctrl_rd = pkt_rd && app_eof && !ctrl_empty;

endmodule

//--- rtl/udp_rx_pkg.sv
package udp_rx_pkg;

  // basic widths
  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [10:0] cpu_addr_t;

  // entries per FIFO
  localparam int PKT_FIFO_DEPTH  = 256;
  localparam int CTRL_FIFO_DEPTH = 4;

  // header lengths in bytes
  localparam int MAC_HDR_LEN = 14;
  localparam int IP_HDR_LEN  = 20;
  localparam int UDP_HDR_LEN = 8;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam byte_t       IP_VER_IHL     = 8'h45;
  localparam byte_t       IP_PROTO_UDP   = 8'h11;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_MAC,
    RX_IP,
    RX_UDP,
    RX_DATA
  } rx_state_e;

  typedef enum logic [1:0] {
    RX_CPU_IDLE,
    RX_CPU_DATA,
    RX_CPU_VALIDATE,
    RX_CPU_HANDSHAKE
  } cpu_state_e;

  // one payload FIFO entry
  typedef struct packed {
    byte_t data;
    logic  eof;
  } rx_byte_t;

  // one control FIFO entry, source of the frame
  typedef struct packed {
    ip_addr_t  ip;
    udp_port_t port;
  } rx_src_t;

  typedef struct packed {
    logic      enable;
    mac_addr_t mac;
    ip_addr_t  ip;
    udp_port_t port;
  } rx_local_t;

  // parser result, aligned with the second byte stage
  typedef struct packed {
    logic app_ok;
    logic cpu_ok;
    logic in_data;
    logic first;
  } rx_verdict_t;

endpackage

//--- verif/udp_rx_props.sv
module udp_rx_props (
  input logic mac_clk,
  input logic mac_rst,
  input logic cpu_ready,
  input logic cpu_ack,
  input logic cpu_wr_en,
  input logic pkt_wr,
  input logic ctrl_wr,
  input logic app_overrun
);

  timeunit 1ns;
  timeprecision 1ps;

  // the page goes back to the DUT only when the CPU acknowledges it
  ready_falls_on_ack: assert property (@(posedge mac_clk) disable iff (mac_rst)
    $fell(cpu_ready) |-> $past(cpu_ack))
    else $error("cpu_ready fell without cpu_ack");

  no_write_while_ready: assert property (@(posedge mac_clk) disable iff (mac_rst)
    cpu_ready |-> !cpu_wr_en)
    else $error("cpu_wr_en high while cpu_ready is high");

  // writer stays blocked while the overrun flag is up
  no_fifo_write_in_overrun: assert property (@(posedge mac_clk) disable iff (mac_rst)
    app_overrun |-> !(pkt_wr || ctrl_wr))
    else $error("FIFO write while app_overrun is set");

  reset_state: assert property (@(posedge mac_clk)
    $fell(mac_rst) |-> !cpu_ready && !app_overrun)
    else $error("cpu_ready or app_overrun not low after reset");

endmodule

bind rx_cpu_buffer udp_rx_props cpu_props_i (
  .mac_clk     (mac_clk),
  .mac_rst     (mac_rst),
  .cpu_ready   (cpu_ready),
  .cpu_ack     (cpu_ack),
  .cpu_wr_en   (cpu_wr_en),
  .pkt_wr      (1'b0),
  .ctrl_wr     (1'b0),
  .app_overrun (1'b0)
);

bind rx_app_writer udp_rx_props app_props_i (
  .mac_clk     (mac_clk),
  .mac_rst     (mac_rst),
  .cpu_ready   (1'b0),
  .cpu_ack     (1'b0),
  .cpu_wr_en   (1'b0),
  .pkt_wr      (pkt_wr),
  .ctrl_wr     (ctrl_wr),
  .app_overrun (app_overrun)
);

//--- verif/udp_rx_tb.sv
module udp_rx_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import udp_rx_pkg::*;

  localparam mac_addr_t LOCAL_MAC  = 48'h02_00_5e_10_20_30;
  localparam mac_addr_t PEER_MAC   = 48'h02_11_22_33_44_55;
  localparam ip_addr_t  LOCAL_IP   = 32'hc0a8_0a05;
  localparam udp_port_t LOCAL_PORT = 16'd5000;
  // about 1700 frame bytes over six tests, doubled, plus handshake waits and margin
  localparam int MAX_CYCLES = 20000;

  logic      mac_clk;
  logic      mac_rst;
  byte_t     mac_rx_data;
  logic      mac_rx_dvld;
  logic      mac_rx_goodframe;
  logic      mac_rx_badframe;
  logic      local_enable;
  mac_addr_t local_mac;
  ip_addr_t  local_ip;
  udp_port_t local_port;
  logic      cpu_promiscuous;
  logic      app_ack = 1'b0;
  logic      app_flush;
  logic      cpu_ack;
  byte_t     app_data;
  logic      app_dvld;
  logic      app_eof;
  ip_addr_t  app_srcip;
  udp_port_t app_srcport;
  logic      app_overrun;
  cpu_addr_t cpu_addr;
  byte_t     cpu_wr_data;
  logic      cpu_wr_en;
  cpu_addr_t cpu_size;
  logic      cpu_ready;
  logic      cpu_buffer_sel;

  byte_t       tx_frame[$];
  byte_t       exp_data[$];
  logic        exp_eof[$];
  ip_addr_t    exp_ip[$];
  udp_port_t   exp_port[$];
  byte_t       got_data[$];
  logic        got_eof[$];
  ip_addr_t    got_ip[$];
  udp_port_t   got_port[$];
  byte_t       cpu_mem[2048];
  int          cpu_wr_count = 0;
  logic        app_en = 1'b0;
  logic [31:0] lcg_state = 32'h1628b5be;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;

  udp_rx dut_i (.*);

  initial mac_clk = 1'b0;
  always #20 mac_clk = ~mac_clk;

  always @(posedge mac_clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // application side, show-ahead read with one pop per cycle
  always @(negedge mac_clk) begin
    app_ack = 1'b0;
    if (app_en && app_dvld) begin
      got_data.push_back(app_data);
      got_eof.push_back(app_eof);
      got_ip.push_back(app_srcip);
      got_port.push_back(app_srcport);
      app_ack = 1'b1;
    end
  end

  // CPU buffer writes, counted from address 0 of each frame
  always @(negedge mac_clk) begin
    if (cpu_wr_en === 1'b1) begin
      if (cpu_addr == '0) begin
        cpu_wr_count = 0;
      end
      cpu_mem[cpu_addr] = cpu_wr_data;
      cpu_wr_count++;
    end
  end

  function automatic byte_t rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s %0d errors", name, errors - errors_before);
    end
  endtask

  // header fields go out msb first
  task automatic push_field(input logic [47:0] value, input int nbytes);
    for (int i = nbytes - 1; i >= 0; i--) begin
      tx_frame.push_back(value[8*i +: 8]);
    end
  endtask

  task automatic build_frame(input mac_addr_t dst_mac, input logic [15:0] etype,
                             input ip_addr_t src_ip, input ip_addr_t dst_ip,
                             input udp_port_t src_port, input udp_port_t dst_port,
                             input int plen);
    tx_frame.delete();
    push_field(dst_mac, 6);
    push_field(PEER_MAC, 6);
    push_field(etype, 2);
    push_field(IP_VER_IHL, 1);
    push_field(0, 1);
    push_field(IP_HDR_LEN + UDP_HDR_LEN + plen, 2);
    push_field(16'h1c46, 2);
    push_field(16'h4000, 2);
    push_field(8'h40, 1);
    push_field(IP_PROTO_UDP, 1);
    push_field(0, 2);
    push_field(src_ip, 4);
    push_field(dst_ip, 4);
    push_field(src_port, 2);
    push_field(dst_port, 2);
    push_field(UDP_HDR_LEN + plen, 2);
    push_field(0, 2);
    for (int i = 0; i < plen; i++) begin
      tx_frame.push_back(rand_byte());
    end
  endtask

  task automatic expect_payload(input ip_addr_t src_ip, input udp_port_t src_port);
    for (int i = MAC_HDR_LEN + IP_HDR_LEN + UDP_HDR_LEN; i < tx_frame.size(); i++) begin
      exp_data.push_back(tx_frame[i]);
      exp_eof.push_back(i == tx_frame.size() - 1);
      exp_ip.push_back(src_ip);
      exp_port.push_back(src_port);
    end
  endtask

  task automatic send_frame(input logic good);
    foreach (tx_frame[i]) begin
      @(negedge mac_clk);
      mac_rx_data = tx_frame[i];
      mac_rx_dvld = 1'b1;
    end
    @(negedge mac_clk);
    mac_rx_data      = '0;
    mac_rx_dvld      = 1'b0;
    mac_rx_goodframe = good;
    mac_rx_badframe  = !good;
    @(negedge mac_clk);
    mac_rx_goodframe = 1'b0;
    mac_rx_badframe  = 1'b0;
  endtask

  task automatic check_app_stream();
    int n;
    for (int k = 0; k < 500 && got_data.size() < exp_data.size(); k++) begin
      @(negedge mac_clk);
    end
    // give stray entries time to show up
    repeat (4) @(negedge mac_clk);
    if (got_data.size() != exp_data.size()) begin
      report_mismatch("app byte count", got_data.size(), exp_data.size());
    end
    n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
    for (int i = 0; i < n; i++) begin
      if (got_data[i] !== exp_data[i]) begin
        report_mismatch($sformatf("app_data[%0d]", i), got_data[i], exp_data[i]);
        break;
      end
      if (got_eof[i] !== exp_eof[i]) begin
        report_mismatch($sformatf("app_eof[%0d]", i), got_eof[i], exp_eof[i]);
        break;
      end
      if (got_ip[i] !== exp_ip[i] || got_port[i] !== exp_port[i]) begin
        report_mismatch($sformatf("app_srcip,app_srcport[%0d]", i),
                        {got_ip[i], got_port[i]}, {exp_ip[i], exp_port[i]});
        break;
      end
    end
    got_data.delete();
    got_eof.delete();
    got_ip.delete();
    got_port.delete();
    exp_data.delete();
    exp_eof.delete();
    exp_ip.delete();
    exp_port.delete();
  endtask

  task automatic check_no_cpu_ready();
    repeat (30) begin
      @(negedge mac_clk);
      if (cpu_ready !== 1'b0) begin
        report_problem("cpu_ready rose for a frame the CPU should not get");
        return;
      end
    end
  endtask

  // waits for ready, checks the captured frame, then acknowledges the page
  task automatic cpu_handshake_check(input int len);
    logic seen;
    logic sel_before;
    seen = 1'b0;
    for (int k = 0; k < 100 && !seen; k++) begin
      @(negedge mac_clk);
      seen = cpu_ready;
    end
    if (!seen) begin
      report_problem("cpu_ready did not rise");
      return;
    end
    if (cpu_size !== cpu_addr_t'(len)) begin
      report_mismatch("cpu_size", cpu_size, len);
    end
    if (cpu_wr_count != len) begin
      report_mismatch("cpu_wr_en count", cpu_wr_count, len);
    end
    for (int i = 0; i < len; i++) begin
      if (cpu_mem[i] !== tx_frame[i]) begin
        report_mismatch($sformatf("cpu_wr_data[%0d]", i), cpu_mem[i], tx_frame[i]);
        break;
      end
    end
    sel_before = cpu_buffer_sel;
    cpu_ack = 1'b1;
    for (int k = 0; k < 20 && seen; k++) begin
      @(negedge mac_clk);
      seen = cpu_ready;
    end
    cpu_ack = 1'b0;
    if (seen) begin
      report_problem("cpu_ready stayed high after cpu_ack");
    end
    if (cpu_buffer_sel !== !sel_before) begin
      report_mismatch("cpu_buffer_sel", cpu_buffer_sel, !sel_before);
    end
    repeat (2) @(negedge mac_clk);
  endtask

  task automatic test_match();
    int e0;
    e0 = errors;
    build_frame(LOCAL_MAC, ETHERTYPE_IPV4, 32'h0a01_0203, LOCAL_IP, 16'd40001, LOCAL_PORT, 64);
    expect_payload(32'h0a01_0203, 16'd40001);
    send_frame(1'b1);
    check_app_stream();
    check_no_cpu_ready();
    finish_test("matching frame", e0);
  endtask

  task automatic test_reject();
    int          e0;
    ip_addr_t    ip;
    udp_port_t   port;
    logic [15:0] etype;
    e0 = errors;
    for (int c = 0; c < 4; c++) begin
      ip           = LOCAL_IP;
      port         = LOCAL_PORT;
      etype        = ETHERTYPE_IPV4;
      local_enable = 1'b1;
      case (c)
        0:       ip = LOCAL_IP ^ 32'h1;
        1:       port = LOCAL_PORT + 16'd1;
        2:       etype = 16'h86dd;
        default: local_enable = 1'b0;
      endcase
      build_frame(LOCAL_MAC, etype, 32'h0a01_0204, ip, 16'd40002, port, 20 + 7 * c);
      send_frame(1'b1);
      check_app_stream();
      cpu_handshake_check(tx_frame.size());
    end
    local_enable = 1'b1;
    finish_test("app reject", e0);
  endtask

  task automatic test_mac_filter();
    int e0;
    e0 = errors;
    build_frame(48'h02_99_88_77_66_55, ETHERTYPE_IPV4, 32'h0a01_0205, LOCAL_IP,
                16'd40003, LOCAL_PORT, 30);
    send_frame(1'b1);
    check_no_cpu_ready();
    cpu_promiscuous = 1'b1;
    send_frame(1'b1);
    cpu_handshake_check(tx_frame.size());
    cpu_promiscuous = 1'b0;
    // broadcast with a foreign port so the application does not take it
    build_frame('1, ETHERTYPE_IPV4, 32'h0a01_0206, LOCAL_IP, 16'd40004, 16'd53, 26);
    send_frame(1'b1);
    cpu_handshake_check(tx_frame.size());
    check_app_stream();
    finish_test("mac filter", e0);
  endtask

  task automatic test_badframe();
    int e0;
    e0 = errors;
    build_frame(LOCAL_MAC, ETHERTYPE_IPV4, 32'h0a01_0207, LOCAL_IP, 16'd40005, 16'd69, 40);
    send_frame(1'b0);
    check_no_cpu_ready();
    build_frame(LOCAL_MAC, ETHERTYPE_IPV4, 32'h0a01_0208, LOCAL_IP, 16'd40006, 16'd69, 33);
    send_frame(1'b1);
    cpu_handshake_check(tx_frame.size());
    finish_test("bad frame", e0);
  endtask

  task automatic test_overrun();
    int e0;
    e0 = errors;
    app_en = 1'b0;
    for (int k = 0; k < 6 && !app_overrun; k++) begin
      build_frame(LOCAL_MAC, ETHERTYPE_IPV4, 32'h0a01_0300, LOCAL_IP, 16'd41000, LOCAL_PORT, 100);
      send_frame(1'b1);
    end
    if (app_overrun !== 1'b1) begin
      report_problem("app_overrun never rose with the FIFO left unread");
    end
    app_flush = 1'b1;
    @(negedge mac_clk);
    app_flush = 1'b0;
    if (app_dvld !== 1'b0) begin
      report_mismatch("app_dvld", app_dvld, 0);
    end
    if (app_overrun !== 1'b0) begin
      report_mismatch("app_overrun", app_overrun, 0);
    end
    @(negedge mac_clk);
    app_en = 1'b1;
    build_frame(LOCAL_MAC, ETHERTYPE_IPV4, 32'h0a01_0301, LOCAL_IP, 16'd41001, LOCAL_PORT, 48);
    expect_payload(32'h0a01_0301, 16'd41001);
    send_frame(1'b1);
    check_app_stream();
    if (app_overrun !== 1'b0) begin
      report_mismatch("app_overrun", app_overrun, 0);
    end
    finish_test("overrun", e0);
  endtask

  task automatic test_back_to_back();
    int e0;
    int plen;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      plen = 1 + (rand_byte() % 48);
      build_frame(LOCAL_MAC, ETHERTYPE_IPV4, 32'h0a00_0010 + i, LOCAL_IP,
                  16'd2000 + 16'(i), LOCAL_PORT, plen);
      expect_payload(32'h0a00_0010 + i, 16'd2000 + 16'(i));
      send_frame(1'b1);
    end
    check_app_stream();
    finish_test("back to back", e0);
  endtask

  initial begin
    mac_rst          = 1'b1;
    mac_rx_data      = '0;
    mac_rx_dvld      = 1'b0;
    mac_rx_goodframe = 1'b0;
    mac_rx_badframe  = 1'b0;
    local_enable     = 1'b1;
    local_mac        = LOCAL_MAC;
    local_ip         = LOCAL_IP;
    local_port       = LOCAL_PORT;
    cpu_promiscuous  = 1'b0;
    app_flush        = 1'b0;
    cpu_ack          = 1'b0;
    repeat (5) @(posedge mac_clk);
    @(negedge mac_clk);
    mac_rst = 1'b0;
    app_en  = 1'b1;
    @(negedge mac_clk);
    test_match();
    test_reject();
    test_mac_filter();
    test_badframe();
    test_overrun();
    test_back_to_back();
    $display("tests run %0d, tests failing %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
